/* build.f */
+incdir+common
common/iso14443a_frame_pkg.sv
common/iso14443a_tx_pkg.sv
common/tx_interface.sv
tx/subcarrier.sv
tx/bit_encoder.sv
tx/tx.sv
hdl/serialiser.sv
hdl/tx_top.sv
verification/tb_tx_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the picc transmit path testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module tb_tx_top --Mdir "$BUILD_DIR" -o tb_tx_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/tb_tx_top" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"

if grep -q "TEST FAILED" "$LOG_FILE"; then
    echo "simulation reported a failure, see $LOG_FILE"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

/* verification/tb_tx_top.sv */
// ==============================
// testbench for the picc transmit
// path, decodes lm_out back to bits
// ==============================

`timescale 1ns/100ps

`include "iso14443a_defines.svh"

module tb_tx_top;
    import iso14443a_frame_pkg::*;

    localparam int NUM_FRAMES   = 3;
    localparam int REQ_TIMEOUT  = 3 * `BYTE_WIDTH * `TICKS_PER_BIT;
    localparam int RISE_TIMEOUT = 32;

    logic  clk = 1'b0;
    logic  rst_n;
    byte_t tx_byte;
    logic  tx_byte_valid;
    logic  tx_byte_req;
    logic  lm_out;

    // high while the card must stay silent
    logic  quiet;
    int    req_pulses = 0;
    byte_t frame_bytes [$];
    // bits still expected on lm_out, soc first
    logic  exp_bits [$];

    tx_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_byte       (tx_byte),
        .tx_byte_valid (tx_byte_valid),
        .tx_byte_req   (tx_byte_req),
        .lm_out        (lm_out)
    );

    // 20 ns carrier clock
    always #10 clk = ~clk;

    // counts every byte request since reset
    always @(posedge clk) begin
        if (rst_n && tx_byte_req) begin
            req_pulses <= req_pulses + 1;
        end
    end

    task automatic end_in_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_mismatch(string signal, int expected, int actual);
        $display("FAILED time=%0t signal=%s expected=%0d actual=%0d",
                 $time, signal, expected, actual);
        end_in_failure();
    endtask

    task automatic plain_failure(string what);
        $display("ERROR at time %0t: %s", $time, what);
        end_in_failure();
    endtask

    // byte request is a single cycle strobe
    assert property (@(posedge clk) disable iff (!rst_n)
        tx_byte_req |=> !tx_byte_req)
        else value_mismatch("tx_byte_req", 0, int'($sampled(tx_byte_req)));

    // nothing leaves the card in a quiet window
    assert property (@(posedge clk) disable iff (!rst_n)
        quiet |-> !lm_out)
        else value_mismatch("lm_out", 0, int'($sampled(lm_out)));

    assert property (@(posedge clk) disable iff (!rst_n)
        quiet |-> !tx_byte_req)
        else value_mismatch("tx_byte_req", 0, int'($sampled(tx_byte_req)));

    task automatic check_quiet(int cycles);
        @(posedge clk);
        quiet <= 1'b1;
        repeat (cycles) @(posedge clk);
        quiet <= 1'b0;
    endtask

    // returns on the edge that sees the registered pulse
    task automatic wait_byte_req();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!tx_byte_req) begin
            if (cycles >= REQ_TIMEOUT) begin
                plain_failure("tx_byte_req did not pulse in time");
            end else begin
                cycles++;
                @(posedge clk);
            end
        end
    endtask

    task automatic send_frame();
        @(posedge clk);
        tx_byte       <= frame_bytes[0];
        tx_byte_valid <= 1'b1;
        // valid is taken at the next edge, lm_out rises two cycles later
        @(posedge clk);
        repeat (2) begin
            @(negedge clk);
            assert (!lm_out) else value_mismatch("lm_out", 0, int'(lm_out));
        end
        @(negedge clk);
        assert (lm_out) else value_mismatch("lm_out", 1, int'(lm_out));
        for (int b = 1; b < frame_bytes.size(); b++) begin
            wait_byte_req();
            tx_byte <= frame_bytes[b];
        end
        wait_byte_req();
        // last byte already held by the serialiser
        tx_byte       <= byte_t'($urandom);
        tx_byte_valid <= 1'b0;
    endtask

    task automatic decode_frame();
        int   cycles;
        int   num_bits;
        logic samples [`TICKS_PER_BIT];
        logic first_active;
        logic second_active;
        logic exp_bit;
        logic exp_level;
        num_bits = exp_bits.size();
        cycles   = 0;
        // anchor on the first modulated cycle
        @(negedge clk);
        while (!lm_out) begin
            if (cycles >= RISE_TIMEOUT) begin
                plain_failure("lm_out never started modulating");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        for (int n = 0; n < num_bits; n++) begin
            first_active  = 1'b0;
            second_active = 1'b0;
            for (int i = 0; i < `TICKS_PER_BIT; i++) begin
                if (n != 0 || i != 0) begin
                    @(negedge clk);
                end
                samples[i] = lm_out;
                if (lm_out && i < `TICKS_PER_BIT / 2) begin
                    first_active = 1'b1;
                end
                if (lm_out && i >= `TICKS_PER_BIT / 2) begin
                    second_active = 1'b1;
                end
            end
            // activity in the first half is a 1, in the second half a 0
            if (first_active == second_active) begin
                plain_failure($sformatf("bit %0d of the frame is no manchester symbol", n));
            end else begin
                exp_bit = exp_bits.pop_front();
                assert (first_active == exp_bit)
                    else value_mismatch("decoded bit", int'(exp_bit), int'(first_active));
                // active half carries the subcarrier, 8 high then 8 low
                for (int i = 0; i < `TICKS_PER_BIT; i++) begin
                    exp_level = (first_active == (i < `TICKS_PER_BIT / 2)) &&
                        ((i % (2 * `SUBCARRIER_HALF_PERIOD)) < `SUBCARRIER_HALF_PERIOD);
                    assert (samples[i] == exp_level)
                        else value_mismatch("lm_out", int'(exp_level), int'(samples[i]));
                end
            end
        end
    endtask

    initial begin
        int len;
        int pulses_before;
        void'($urandom(32'he39d));
        rst_n         = 1'b0;
        tx_byte       = '0;
        tx_byte_valid = 1'b0;
        quiet         = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // idle card with no byte offered
        check_quiet(`TICKS_PER_BIT / 2);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            len = 1 + int'($urandom % 4);
            frame_bytes.delete();
            exp_bits.delete();
            // soc bit leads every frame
            exp_bits.push_back(1'b1);
            for (int b = 0; b < len; b++) begin
                frame_bytes.push_back(byte_t'($urandom));
                for (int j = 0; j < `BYTE_WIDTH; j++) begin
                    exp_bits.push_back(frame_bytes[b][j]);
                end
            end
            pulses_before = req_pulses;
            fork
                send_frame();
                decode_frame();
            join
            assert (req_pulses - pulses_before == len)
                else value_mismatch("tx_byte_req pulses", len, req_pulses - pulses_before);
            // silent for more than a bit period before the next frame
            check_quiet(`TICKS_PER_BIT + 16);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

/* hdl/tx_top.sv */
// ============================
// picc transmit path top level
// ============================

`timescale 1ns/100ps

module tx_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // user byte side
    input  iso14443a_frame_pkg::byte_t tx_byte,
    input  logic                       tx_byte_valid,
    output logic                       tx_byte_req,
    // to the load modulator
    output logic                       lm_out
);

    // bit stream from serialiser to sequencer
    tx_interface ser_iface ();

    serialiser u_serialiser (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_byte       (tx_byte),
        .tx_byte_valid (tx_byte_valid),
        .tx_byte_req   (tx_byte_req),
        .out_iface     (ser_iface)
    );

    // soc insertion, manchester coding and subcarrier
    tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_iface (ser_iface),
        .lm_out   (lm_out)
    );

endmodule

/* hdl/serialiser.sv */
// ============================
// byte to lsb first bit stream
// ============================

`timescale 1ns/100ps

`include "iso14443a_defines.svh"

module serialiser (
    input  logic                       clk,
    input  logic                       rst_n,
    input  iso14443a_frame_pkg::byte_t tx_byte,
    input  logic                       tx_byte_valid,
    output logic                       tx_byte_req,
    tx_interface.out_bit               out_iface
);
    import iso14443a_frame_pkg::*;

    bit_index_t idx;
    byte_t      byte_q;
    logic       last_bit;

    assign last_bit = (idx == bit_index_t'(`BYTE_WIDTH - 1));

    // bit 0 comes straight from the port so a new byte follows without a gap
    // later bits come from the copy taken when bit 0 was consumed
    assign out_iface.data = (idx == '0) ? tx_byte[0] : byte_q[idx];

    // a started byte always runs to its last bit
    assign out_iface.data_valid       = tx_byte_valid || (idx != '0);
    assign out_iface.last_bit_in_byte = last_bit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx         <= '0;
            tx_byte_req <= 1'b0;
        end else begin
            tx_byte_req <= 1'b0;
            if (out_iface.req) begin
                idx <= last_bit ? bit_index_t'(0) : idx + bit_index_t'(1);
                // moving on to bit 7, user may now load the next byte
                if (idx == bit_index_t'(`BYTE_WIDTH - 2)) begin
                    tx_byte_req <= 1'b1;
                end
            end
        end
    end

    // hold the byte once its first bit is gone
    always_ff @(posedge clk) begin
        if (out_iface.req && (idx == '0)) begin
            byte_q <= tx_byte;
        end
    end

    // the consumer only asks while a bit is on offer
    assert property (@(posedge clk) disable iff (!rst_n)
        out_iface.req |-> out_iface.data_valid)
        else $error("serialiser: req while data_valid low");

endmodule

/* tx/tx.sv */
// ============================
// tx sequencer, inserts soc and
// drives encoder and subcarrier
// ============================

`timescale 1ns/100ps

module tx (
    input  logic        clk,
    input  logic        rst_n,
    tx_interface.in_bit in_iface,
    output logic        lm_out
);
    import iso14443a_tx_pkg::*;

    tx_state_t state;
    logic      en;
    logic      bit_to_send;
    logic      in_req;
    logic      be_last_tick;
    logic      sc_out;
    logic      encoded_data;

    // link from the sequencer to the bit encoder
    tx_interface be_iface ();

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= state_idle;
            in_req <= 1'b0;
        end else begin
            // req is a single cycle strobe
            in_req <= 1'b0;
            case (state)
                state_idle: begin
                    // first valid bit starts a frame with the soc
                    if (in_iface.data_valid) begin
                        state <= state_soc;
                    end
                end
                state_soc: begin
                    // encoder has latched the soc bit
                    if (be_iface.req) begin
                        state <= state_data;
                    end
                end
                state_data: begin
                    // encoder took the serialiser bit, ask for the next one
                    if (be_iface.req && in_iface.data_valid) begin
                        in_req <= 1'b1;
                    end else if (be_last_tick && !in_iface.data_valid) begin
                        // unmodulated period done, frame over
                        state <= state_idle;
                    end
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    assign in_iface.req = in_req;

    assign en = (state != state_idle);

    // soc is always logic 1
    assign bit_to_send = (state == state_soc) ? 1'b1 : in_iface.data;

    assign be_iface.data             = bit_to_send;
    assign be_iface.data_valid       = (state == state_soc) ||
                                       ((state == state_data) && in_iface.data_valid);
    assign be_iface.last_bit_in_byte = in_iface.last_bit_in_byte;

    subcarrier u_subcarrier (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .subcarrier (sc_out)
    );

    bit_encoder u_bit_encoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .in_iface     (be_iface),
        .encoded_data (encoded_data),
        .last_tick    (be_last_tick)
    );

    // registered so no glitch reaches the load modulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lm_out <= 1'b0;
        end else begin
            lm_out <= sc_out & encoded_data;
        end
    end

    // the serialiser never sees two bit requests back to back
    assert property (@(posedge clk) disable iff (!rst_n)
        in_iface.req |=> !in_iface.req)
        else $error("tx: req to serialiser high for two cycles");

    // idle keeps the modulator quiet through subcarrier and output registers
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == state_idle) |-> ##2 !lm_out)
        else $error("tx: lm_out active two cycles after idle");

endmodule

/* tx/bit_encoder.sv */
// ============================
// manchester encoder over one
// 128 tick bit period
// ============================

`timescale 1ns/100ps

`include "iso14443a_defines.svh"

module bit_encoder (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    tx_interface.in_bit in_iface,
    output logic        encoded_data,
    output logic        last_tick
);
    import iso14443a_tx_pkg::*;

    tick_t tick;
    logic  bit_q;
    logic  valid_q;
    logic  first_half;

    // free running tick counter, held at 0 while disabled
    // so each frame starts at the top of a bit period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick <= '0;
        end else if (!en) begin
            tick <= '0;
        end else begin
            tick <= tick + tick_t'(1);
        end
    end

    // take a new bit at tick 0 of every period
    assign in_iface.req = en && (tick == '0);

    // bit value of the current period
    always_ff @(posedge clk) begin
        if (in_iface.req) begin
            bit_q <= in_iface.data;
        end
    end

    // an invalid bit gives an unmodulated period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_iface.req) begin
            valid_q <= in_iface.data_valid;
        end
    end

    assign first_half = (tick < tick_t'(`TICKS_PER_BIT / 2));

    // logic 1 active in the first half, logic 0 in the second half
    // tick 0 falls in a subcarrier low phase so the old bit there is harmless
    assign encoded_data = en && valid_q && (bit_q == first_half);

    assign last_tick = en && (tick == tick_t'(`TICKS_PER_BIT - 1));

    // one req per bit period, never in the middle of one
    assert property (@(posedge clk) disable iff (!rst_n)
        in_iface.req |=> !in_iface.req [*`TICKS_PER_BIT - 1])
        else $error("bit_encoder: req inside a bit period");

endmodule

/* tx/subcarrier.sv */
// ============================
// fc/16 subcarrier with enable
// ============================

`timescale 1ns/100ps

module subcarrier (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    output logic subcarrier
);
    import iso14443a_tx_pkg::*;

    // phase within the current half period
    sc_count_t count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count      <= '0;
            subcarrier <= 1'b0;
        end else if (!en) begin
            // cleared while disabled
            // keeps every frame in the same phase
            count      <= '0;
            subcarrier <= 1'b0;
        end else begin
            // toggle on the wrap, first enabled edge drives high
            if (count == '0) begin
                subcarrier <= ~subcarrier;
            end
            // counter width gives the 8 tick half period
            count <= count + sc_count_t'(1);
        end
    end

endmodule

/* common/tx_interface.sv */
// ============================
// single bit stream between a
// source and a consumer
// ============================

`timescale 1ns/100ps

interface tx_interface;

    // bit to send, only meaningful while data_valid is high
    logic data;
    logic data_valid;
    // marks bit 7 of the current byte
    logic last_bit_in_byte;
    // one cycle strobe from the consumer
    // current bit taken, next one or drop data_valid
    logic req;

    modport out_bit (
        output data,
        output data_valid,
        output last_bit_in_byte,
        input  req
    );

    modport in_bit (
        input  data,
        input  data_valid,
        input  last_bit_in_byte,
        output req
    );

endinterface

/* common/iso14443a_tx_pkg.sv */
// ============================
// modulation side types for the
// picc transmit path
// ============================

`include "iso14443a_defines.svh"

package iso14443a_tx_pkg;

    // tick count within one bit period
    typedef logic [$clog2(`TICKS_PER_BIT)-1:0] tick_t;

    // subcarrier phase counter, wraps once per half period
    typedef logic [$clog2(`SUBCARRIER_HALF_PERIOD)-1:0] sc_count_t;

    // sequencer states
    // eoc is just the unmodulated time after the last bit
    typedef enum logic [1:0] {
        state_idle,
        state_soc,
        state_data
    } tx_state_t;

endpackage

/* common/iso14443a_frame_pkg.sv */
// ============================
// data side types for the
// picc transmit path
// ============================

`include "iso14443a_defines.svh"

package iso14443a_frame_pkg;

    // one user data byte
    // sent lsb first after the soc bit
    typedef logic [`BYTE_WIDTH-1:0] byte_t;

    // position of the current bit inside its byte
    typedef logic [$clog2(`BYTE_WIDTH)-1:0] bit_index_t;

endpackage

/* common/iso14443a_defines.svh */
// ============================
// iso 14443a picc transmit timing
// and width constants
// ============================

`ifndef ISO14443A_DEFINES_SVH
`define ISO14443A_DEFINES_SVH

// carrier ticks in one bit period (fc/128)
`define TICKS_PER_BIT 128

// subcarrier is fc/16, so it stays high or low for 8 ticks
`define SUBCARRIER_HALF_PERIOD 8

// bits per user byte
`define BYTE_WIDTH 8

`endif
